/* Makefile */
VERILATOR  ?= verilator
TOP        := intPipeTb
RTLTOP     := intPipe
FILELIST   := intPipe.f
BUILDFLAGS := --binary --assert --top-module $(TOP)
LINTFLAGS  := --lint-only -Wall --timing --top-module $(TOP)
OBJDIR     := obj_dir
LOG        := sim.log
FAILMSG    := SIMULATION FAILED
PASSMSG    := SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILDFLAGS) -f $(FILELIST)

run: build
	-./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASSMSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* intPipe.f */
src/intPipePkg.sv
src/decodeStage.sv
src/regFile.sv
src/issueStage.sv
src/executeStage.sv
src/intPipe.sv
verification/intPipe_chk.sv
verification/intPipeTb.sv

/* src/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
	input logic clk,
	input logic nrst,
	input logic instrValid,			// high when instr holds a real instruction
	input intPipePkg::wordT instr,		// raw instruction word
	output intPipePkg::regAddrT rs1,	// source register a
	output intPipePkg::regAddrT rs2,	// source register b
	output intPipePkg::regAddrT rd,		// destination register
	output intPipePkg::immT imm,		// i-type immediate
	output intPipePkg::shamtT shamt,	// shift amount for slli/srli/srai
	output intPipePkg::bSelT bSel,		// operand b source
	output intPipePkg::aluFnT aluFn,	// alu function
	output logic fn,			// sub / sra select
	output logic we				// register file write for this instruction
	);

	// major opcodes handled here
	localparam logic [6:0] opcOp    = 7'b0110011;	// register-register
	localparam logic [6:0] opcOpImm = 7'b0010011;	// register-immediate

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	logic nextWe;
	logic nextFn;
	intPipePkg::bSelT nextBSel;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// classify the word, anything not matched leaves we low
	always_comb
	begin
		nextWe   = 1'b0;
		nextFn   = 1'b0;
		nextBSel = intPipePkg::selReg;
		unique case (opcode)
			opcOp:
			begin
				if (funct7 == 7'b0000000)
					nextWe = 1'b1;		// add, sll, slt, sltu, xor, srl, or, and
				else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))
				begin
					nextWe = 1'b1;		// sub or sra
					nextFn = 1'b1;
				end
			end
			opcOpImm:
			begin
				unique case (funct3)
					3'b001:				// slli
					begin
						nextBSel = intPipePkg::selShamt;
						nextWe   = (funct7 == 7'b0000000);
					end
					3'b101:				// srli / srai
					begin
						nextBSel = intPipePkg::selShamt;
						nextWe   = (funct7 == 7'b0000000 || funct7 == 7'b0100000);
						nextFn   = funct7[5];	// instr bit 30
					end
					3'b011: ;			// sltiu is not in the subset
					default:			// addi, slti, xori, ori, andi
					begin
						nextBSel = intPipePkg::selImm;
						nextWe   = 1'b1;
					end
				endcase
			end
			default: ;				// unsupported opcode, bubble
		endcase
		if (!instrValid)
			nextWe = 1'b0;				// empty slot never writes
	end

	// decode register
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			rs1   <= '0;
			rs2   <= '0;
			rd    <= '0;
			imm   <= '0;
			shamt <= '0;
			bSel  <= intPipePkg::selReg;
			aluFn <= intPipePkg::aluAdd;
			fn    <= 1'b0;
			we    <= 1'b0;
		end
		else
		begin
			rs1   <= instr[19:15];
			rs2   <= instr[24:20];
			rd    <= instr[11:7];
			imm   <= instr[31:20];
			shamt <= instr[24:20];			// same bits as rs2
			bSel  <= nextBSel;
			aluFn <= intPipePkg::aluFnT'({1'b0, funct3});
			fn    <= nextFn;
			we    <= nextWe;
		end
	end

endmodule

/* src/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic nrst,
	input intPipePkg::wordT opA,		// from issue
	input intPipePkg::wordT opB,
	input intPipePkg::aluFnT aluFn,
	input logic fn,				// sub / sra select
	input logic we,
	input intPipePkg::regAddrT rd,
	output logic retireWe,			// retire register, also the write-back port
	output intPipePkg::regAddrT retireRd,
	output intPipePkg::wordT retireData
	);

	logic [4:0] sh;			// shifts only look at the low five bits
	logic lessSigned;
	logic lessUnsigned;
	intPipePkg::wordT aluResult;

	assign sh           = opB[4:0];
	assign lessSigned   = $signed(opA) < $signed(opB);
	assign lessUnsigned = opA < opB;

	// alu
	always_comb
	begin
		unique case (aluFn)
			intPipePkg::aluAdd:
			begin
				if (fn)
					aluResult = opA - opB;		// sub
				else
					aluResult = opA + opB;
			end
			intPipePkg::aluSll:  aluResult = opA << sh;
			intPipePkg::aluSlt:  aluResult = {31'b0, lessSigned};
			intPipePkg::aluSltu: aluResult = {31'b0, lessUnsigned};
			intPipePkg::aluXor:  aluResult = opA ^ opB;
			intPipePkg::aluSrl:
			begin
				if (fn)
					aluResult = $signed(opA) >>> sh;	// sra keeps the sign
				else
					aluResult = opA >> sh;
			end
			intPipePkg::aluOr:   aluResult = opA | opB;
			intPipePkg::aluAnd:  aluResult = opA & opB;
			default:             aluResult = '0;	// bit 3 set, never decoded
		endcase
	end

	// retire register
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			retireWe   <= 1'b0;
			retireRd   <= '0;
			retireData <= '0;
		end
		else
		begin
			retireWe   <= we;		// bubbles retire with we low
			retireRd   <= rd;
			retireData <= aluResult;
		end
	end

endmodule

/* src/intPipe.sv */
`timescale 1ns/1ps

module intPipe (
	input logic clk,
	input logic nrst,
	input logic instrValid,
	input intPipePkg::wordT instr,
	output logic retireWe,
	output intPipePkg::regAddrT retireRd,
	output intPipePkg::wordT retireData
	);

	// decode -> issue
	intPipePkg::regAddrT decRs1, decRs2, decRd;
	intPipePkg::immT decImm;
	intPipePkg::shamtT decShamt;
	intPipePkg::bSelT decBSel;
	intPipePkg::aluFnT decAluFn;
	logic decFn, decWe;

	// issue -> execute
	intPipePkg::wordT exOpA, exOpB;
	intPipePkg::aluFnT exAluFn;
	logic exFn, exWe;
	intPipePkg::regAddrT exRd;

	decodeStage decode (
		.clk(clk),
		.nrst(nrst),
		.instrValid(instrValid),
		.instr(instr),
		.rs1(decRs1),
		.rs2(decRs2),
		.rd(decRd),
		.imm(decImm),
		.shamt(decShamt),
		.bSel(decBSel),
		.aluFn(decAluFn),
		.fn(decFn),
		.we(decWe)
	);

	issueStage issue (
		.clk(clk),
		.nrst(nrst),
		.rs1(decRs1),
		.rs2(decRs2),
		.decRd(decRd),
		.imm(decImm),
		.shamt(decShamt),
		.bSel(decBSel),
		.decAluFn(decAluFn),
		.decFn(decFn),
		.decWe(decWe),
		.wbWe(retireWe),		// write-back loop from the retire register
		.wbRd(retireRd),
		.wbData(retireData),
		.opA(exOpA),
		.opB(exOpB),
		.aluFn(exAluFn),
		.fn(exFn),
		.we(exWe),
		.rd(exRd)
	);

	executeStage execute (
		.clk(clk),
		.nrst(nrst),
		.opA(exOpA),
		.opB(exOpB),
		.aluFn(exAluFn),
		.fn(exFn),
		.we(exWe),
		.rd(exRd),
		.retireWe(retireWe),
		.retireRd(retireRd),
		.retireData(retireData)
	);

endmodule

/* src/intPipePkg.sv */
package intPipePkg;

	// widths fixed by the rv32 instruction encoding
	typedef logic [31:0] wordT;	// operand, result or instruction word
	typedef logic [4:0] regAddrT;	// x0..x31
	typedef logic [11:0] immT;	// i-type immediate, still unextended
	typedef logic [4:0] shamtT;	// shift amount from the immediate field
	typedef logic [3:0] aluFnT;	// alu function select
	typedef logic [1:0] bSelT;	// operand b source select

	// alu function codes
	// the low three bits equal funct3, so decode can pass funct3 through unchanged
	localparam aluFnT aluAdd  = 4'b0000;	// sub when fn is set
	localparam aluFnT aluSll  = 4'b0001;
	localparam aluFnT aluSlt  = 4'b0010;	// signed compare
	localparam aluFnT aluSltu = 4'b0011;	// unsigned compare
	localparam aluFnT aluXor  = 4'b0100;
	localparam aluFnT aluSrl  = 4'b0101;	// sra when fn is set
	localparam aluFnT aluOr   = 4'b0110;
	localparam aluFnT aluAnd  = 4'b0111;

	// operand b select codes, 2'b11 is unused and falls back to the register
	localparam bSelT selReg   = 2'b00;	// rs2 from the register file
	localparam bSelT selImm   = 2'b01;	// sign-extended immediate
	localparam bSelT selShamt = 2'b10;	// zero-extended shift amount

endpackage

/* src/issueStage.sv */
`timescale 1ns/1ps

module issueStage (
	input logic clk,
	input logic nrst,
	input intPipePkg::regAddrT rs1,		// from decode
	input intPipePkg::regAddrT rs2,
	input intPipePkg::regAddrT decRd,
	input intPipePkg::immT imm,
	input intPipePkg::shamtT shamt,
	input intPipePkg::bSelT bSel,
	input intPipePkg::aluFnT decAluFn,
	input logic decFn,
	input logic decWe,
	input logic wbWe,			// write-back port from execute
	input intPipePkg::regAddrT wbRd,
	input intPipePkg::wordT wbData,
	output intPipePkg::wordT opA,		// operands to execute
	output intPipePkg::wordT opB,
	output intPipePkg::aluFnT aluFn,
	output logic fn,
	output logic we,
	output intPipePkg::regAddrT rd
	);

	// issue pipe register
	intPipePkg::regAddrT pipeRs1, pipeRs2, pipeRd;
	intPipePkg::immT pipeImm;
	intPipePkg::shamtT pipeShamt;
	intPipePkg::bSelT pipeBSel;
	intPipePkg::aluFnT pipeAluFn;
	logic pipeFn;
	logic pipeWe;

	intPipePkg::wordT regB;		// rs2 value straight from the register file

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pipeRs1   <= '0;
			pipeRs2   <= '0;
			pipeRd    <= '0;
			pipeImm   <= '0;
			pipeShamt <= '0;
			pipeBSel  <= intPipePkg::selReg;
			pipeAluFn <= intPipePkg::aluAdd;
			pipeFn    <= 1'b0;
			pipeWe    <= 1'b0;
		end
		else
		begin
			pipeRs1   <= rs1;
			pipeRs2   <= rs2;
			pipeRd    <= decRd;
			pipeImm   <= imm;
			pipeShamt <= shamt;
			pipeBSel  <= bSel;
			pipeAluFn <= decAluFn;			// controls ride along to execute
			pipeFn    <= decFn;
			pipeWe    <= decWe;
		end
	end

	regFile rf (
		.clk(clk),
		.nrst(nrst),
		.we(wbWe),
		.writeAddr(wbRd),
		.writeData(wbData),
		.srcA(pipeRs1),
		.srcB(pipeRs2),
		.opA(opA),
		.opB(regB)
	);

	// operand b source
	always_comb
	begin
		unique case (pipeBSel)
			intPipePkg::selImm:   opB = {{20{pipeImm[11]}}, pipeImm};	// sign-extend
			intPipePkg::selShamt: opB = {27'b0, pipeShamt};
			default:              opB = regB;		// register and the spare code
		endcase
	end

	assign aluFn = pipeAluFn;
	assign fn    = pipeFn;
	assign we    = pipeWe;
	assign rd    = pipeRd;

endmodule

/* src/regFile.sv */
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic nrst,
	input logic we,				// write strobe from the retire register
	input intPipePkg::regAddrT writeAddr,
	input intPipePkg::wordT writeData,
	input intPipePkg::regAddrT srcA,	// read port a address
	input intPipePkg::regAddrT srcB,	// read port b address
	output intPipePkg::wordT opA,
	output intPipePkg::wordT opB
	);

	// x1..x31, x0 has no storage
	intPipePkg::wordT regs [1:31];

	logic hitA;
	logic hitB;

	// write port, x0 writes are dropped
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && writeAddr != '0)
			regs[writeAddr] <= writeData;
	end

	// write-through: a read of the address being written this cycle
	// sees the new data, so a dependent instruction right behind its producer is fine
	assign hitA = we && (srcA == writeAddr);
	assign hitB = we && (srcB == writeAddr);

	always_comb
	begin
		if (srcA == '0)
			opA = '0;			// x0 always reads zero, even with a bypass hit
		else if (hitA)
			opA = writeData;
		else
			opA = regs[srcA];
	end

	always_comb
	begin
		if (srcB == '0)
			opB = '0;
		else if (hitB)
			opB = writeData;
		else
			opB = regs[srcB];
	end

endmodule

/* verification/intPipeTb.sv */
`timescale 1ns/1ps

module intPipeTb;

	localparam int clkPeriod = 20;		// ns
	localparam int resetCycles = 5;
	localparam int latency = 3;		// edges between sampling and retire
	localparam int maxGap = 3;		// longest random bubble run
	localparam int slackCycles = 20;
	localparam string traceFile = "verification/intPipe_trace.txt";

	logic clk;
	logic nrst;
	logic instrValid;
	intPipePkg::wordT instr;
	logic retireWe;
	intPipePkg::regAddrT retireRd;
	intPipePkg::wordT retireData;

	// trace columns, one element per line of the file
	logic traceValid [$];
	logic traceWe [$];
	intPipePkg::wordT traceInstr [$];
	intPipePkg::regAddrT traceRd [$];
	intPipePkg::wordT traceData [$];

	int gaps [$];			// bubble run ahead of each entry in the second pass
	int gapTotal;
	int checkedCount;
	longint timeLimit;		// watchdog budget in ns, zero until armed

	// expectations in flight, oldest at the front
	logic expWe [$];
	intPipePkg::regAddrT expRd [$];
	intPipePkg::wordT expData [$];

	intPipe uut (
		.clk(clk),
		.nrst(nrst),
		.instrValid(instrValid),
		.instr(instr),
		.retireWe(retireWe),
		.retireRd(retireRd),
		.retireData(retireData)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(clkPeriod / 2) clk = ~clk;
	end

	task automatic abortRun();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic loadTrace();
		int fd;
		int rv;
		int fields;
		int fv;
		int fwe;
		string line;
		intPipePkg::wordT fins;
		intPipePkg::regAddrT frd;
		intPipePkg::wordT fdata;
		fd = $fopen(traceFile, "r");
		if (fd == 0)
		begin
			$display("cannot open the trace file %s", traceFile);
			abortRun();
		end
		while (!$feof(fd))
		begin
			rv = $fgets(line, fd);
			fields = $sscanf(line, "%h %h %h %h %h", fv, fwe, fins, frd, fdata);
			if (rv > 0 && fields == 5)	// comment and blank lines never scan five fields
			begin
				traceValid.push_back(fv != 0);
				traceWe.push_back(fwe != 0);
				traceInstr.push_back(fins);
				traceRd.push_back(frd);
				traceData.push_back(fdata);
			end
		end
		$fclose(fd);
		if (traceInstr.size() == 0)
		begin
			$display("the trace file holds no entries");
			abortRun();
		end
	endtask

	// bubble runs for the second pass, latency is fixed so results do not move
	task automatic pickGaps();
		gapTotal = 0;
		for (int i = 0; i < traceInstr.size(); i++)
		begin
			gaps.push_back(int'($urandom % (maxGap + 1)));
			gapTotal += gaps[i];
		end
	endtask

	// rd and data only matter when something retires
	task automatic checkRetire(input logic we, input intPipePkg::regAddrT rd,
		input intPipePkg::wordT data);
		checkedCount++;
		assert (retireWe === we)
		else
		begin
			$display("ERR retireWe expected %h got %h", we, retireWe);
			abortRun();
		end
		if (we)
		begin
			assert (retireRd === rd)
			else
			begin
				$display("ERR retireRd expected %h got %h", rd, retireRd);
				abortRun();
			end
			assert (retireData === data)
			else
			begin
				$display("ERR retireData expected %h got %h", data, retireData);
				abortRun();
			end
		end
	endtask

	// one cycle: check what is due, then drive the next slot
	task automatic stepCycle(input logic valid, input intPipePkg::wordT word, input logic we,
		input intPipePkg::regAddrT rd, input intPipePkg::wordT data);
		@(negedge clk);
		if (expWe.size() == latency)
			checkRetire(expWe.pop_front(), expRd.pop_front(), expData.pop_front());
		instrValid = valid;
		instr = word;
		expWe.push_back(we);
		expRd.push_back(rd);
		expData.push_back(data);
	endtask

	task automatic driveEntry(input int idx);
		stepCycle(traceValid[idx], traceInstr[idx], traceWe[idx], traceRd[idx], traceData[idx]);
	endtask

	task automatic driveBubble();
		stepCycle(1'b0, '0, 1'b0, '0, '0);
	endtask

	initial
	begin
		nrst = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		checkedCount = 0;
		timeLimit = 0;
		void'($urandom(55));
		loadTrace();
		pickGaps();
		timeLimit = longint'(2 * traceInstr.size() + gapTotal + slackCycles) * clkPeriod;
		repeat (resetCycles)
			@(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		// first pass back to back, every dependency goes through the bypass
		for (int i = 0; i < traceInstr.size(); i++)
			driveEntry(i);
		// second pass, same program with random bubble runs in between
		for (int i = 0; i < traceInstr.size(); i++)
		begin
			repeat (gaps[i])
				driveBubble();
			driveEntry(i);
		end
		repeat (latency)
			driveBubble();		// drain the last entries
		if (checkedCount == 2 * traceInstr.size() + gapTotal)
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
		else
		begin
			$display("only %0d retire slots were checked", checkedCount);
			abortRun();
		end
	end

	// watchdog
	initial
	begin
		wait (timeLimit != 0);
		#(timeLimit);
		$display("the run timed out after %0d ns before the trace was done", timeLimit);
		abortRun();
	end

endmodule

/* verification/intPipe_chk.sv */
`timescale 1ns/1ps

module intPipe_chk (
	input logic clk,
	input logic nrst,
	input logic instrValid,
	input intPipePkg::wordT instr,
	input logic retireWe,
	input intPipePkg::wordT retireData
	);

	// addi rX, x0, 0 for any rd
	localparam intPipePkg::wordT zeroAddiMask = 32'hffff_f07f;
	localparam intPipePkg::wordT zeroAddi = 32'h0000_0013;

	logic [6:0] opc;
	logic [2:0] f3;
	logic [6:0] f7;
	logic regOk;		// add, sub, sll, slt, sltu, xor, srl, sra, or, and
	logic immOk;		// addi, slti, xori, ori, andi, slli, srli, srai
	logic supported;
	logic zeroRead;

	assign opc = instr[6:0];
	assign f3  = instr[14:12];
	assign f7  = instr[31:25];

	// funct7 is zero for every register op, 0x20 only for sub and sra
	assign regOk = opc == 7'b0110011
		&& (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
	// sltiu is left out, shift immediates carry a funct7 like the register shifts
	assign immOk = opc == 7'b0010011 && f3 != 3'b011
		&& (f3 != 3'b001 || f7 == 7'h00)
		&& (f3 != 3'b101 || f7 == 7'h00 || f7 == 7'h20);
	assign supported = instrValid && (regOk || immOk);

	assign zeroRead = instrValid && ((instr & zeroAddiMask) == zeroAddi);

	// nothing retires while reset is held
	resetQuiet: assert property (@(posedge clk) !nrst |-> !retireWe)
		else $error("retireWe high during reset");

	afterReset: assert property (@(posedge clk) $rose(nrst) |=> !retireWe)
		else $error("retireWe high in the first cycle after reset");

	// a valid supported word retires three edges later, anything else retires as a bubble
	weFollows: assert property (@(posedge clk) disable iff (!nrst)
		retireWe == $past(supported, 3))
		else $error("retireWe does not follow the instruction three cycles before");

	// earlier writes to x0 must not leak into a read of x0
	x0Zero: assert property (@(posedge clk) disable iff (!nrst)
		$past(zeroRead, 3) |-> retireWe && retireData == '0)
		else $error("read of x0 returned a nonzero value");

endmodule

bind intPipe intPipe_chk chk (
	.clk(clk),
	.nrst(nrst),
	.instrValid(instrValid),
	.instr(instr),
	.retireWe(retireWe),
	.retireData(retireData)
);

/* verification/intPipe_trace.txt */
# valid we instr rd data, all hex, valid 0 is an empty slot
# we 0 means nothing may retire, rd and data are then ignored
0 0 00000000 00 00000000	# empty slots right after reset
0 0 00000000 00 00000000
1 1 00500093 01 00000005	# addi x1, x0, 5
1 1 ffd00113 02 fffffffd	# addi x2, x0, -3
1 1 0f017193 03 000000f0	# andi x3, x2, 0x0f0
1 1 ff00e213 04 fffffff5	# ori x4, x1, -16
1 1 7ff24293 05 fffff80a	# xori x5, x4, 0x7ff
1 1 ffe12313 06 00000001	# slti x6, x2, -2
1 1 fff0a393 07 00000000	# slti x7, x1, -1
1 1 00208433 08 00000002	# add x8, x1, x2
1 1 402084b3 09 00000008	# sub x9, x1, x2
1 1 00417533 0a fffffff5	# and x10, x2, x4
1 1 0011e5b3 0b 000000f5	# or x11, x3, x1
1 1 0042c633 0c 000007ff	# xor x12, x5, x4
1 1 00100693 0d 00000001	# addi x13, x0, 1
1 1 fff00713 0e ffffffff	# addi x14, x0, -1
1 1 00d727b3 0f 00000001	# slt x15, x14, x13
1 1 00d73833 10 00000000	# sltu x16, x14, x13
1 1 02400893 11 00000024	# addi x17, x0, 36
1 1 01109933 12 00000050	# sll x18, x1, x17
1 1 011759b3 13 0fffffff	# srl x19, x14, x17
1 1 4112da33 14 ffffff80	# sra x20, x5, x17
1 1 01f09a93 15 80000000	# slli x21, x1, 31
1 1 003adb13 16 10000000	# srli x22, x21, 3
1 1 403adb93 17 f0000000	# srai x23, x21, 3
1 1 06400c13 18 00000064	# addi x24, x0, 100
1 1 001c0d93 1b 00000065	# addi x27, x24, 1
1 1 01bd8cb3 19 000000ca	# add x25, x27, x27
1 1 41bc8d33 1a 00000065	# sub x26, x25, x27
0 0 00000000 00 00000000
1 0 123452b7 00 00000000	# lui x5 is outside the subset
1 0 00a0b313 00 00000000	# sltiu x6, x1, 10 is outside too
1 0 401093b3 00 00000000	# sll with funct7 0x20
0 0 00500493 00 00000000	# addi x9, x0, 5 with valid low
1 1 00708013 00 0000000c	# addi x0, x1, 7 retires but x0 stays zero
1 1 00000e93 1d 00000000	# addi x29, x0, 0
1 1 00900f33 1e 00000008	# add x30, x0, x9
1 1 00030e13 1c 00000001	# addi x28, x6, 0
1 1 00028f93 1f fffff80a	# addi x31, x5, 0
